//--- files.f
+incdir+source
source/path_types_pkg.sv
source/path_ctrl_pkg.sv
source/count_accumulator.sv
source/node_queue.sv
source/path_count_ctrl.sv
source/path_count_top.sv
testbench/tb_clock_gen.sv
testbench/path_count_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the path counter testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_MSG="Done: errors found"

verilator --binary --timing --assert \
    -f files.f --top-module path_count_tb \
    -Mdir "$BUILD_DIR" -o path_count_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/path_count_sim" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG_FILE"; then
    echo "Simulation reported errors"
    exit 1
fi
echo "Simulation passed"
exit 0

//--- source/count_accumulator.sv
// Count accumulator: end node registers, end match and the shared count adder
`timescale 1ns/10ps

module count_accumulator
    import path_types_pkg::*;
    import path_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        end_load,
    input  logic        end_add,
    input  node_idx_t   end_node,
    input  node_idx_t   next_node_idx,
    input  add_base_t   add_base,
    input  path_count_t match_count,
    input  path_count_t popped_count,

    output path_count_t sum,
    output logic        end_hit,
    output path_count_t path_count
);

    node_idx_t   end_idx;
    path_count_t end_count;

    path_count_t base;
    path_count_t addend;

    // Base operand
    always_comb begin
        case (add_base)
            BASE_END:   base = end_count;
            BASE_MATCH: base = match_count;
            default:    base = '0;
        endcase
    end

    // Seed gets the constant 1, everything else adds the popped count
    assign addend = (add_base == BASE_SEED) ? path_count_t'(1) : popped_count;
    assign sum    = base + addend;

    assign end_hit    = (next_node_idx == end_idx);
    assign path_count = end_count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            end_idx   <= '0;
            end_count <= '0;
        end else if (end_load) begin
            end_idx   <= end_node;
            end_count <= '0;
        end else if (end_add) begin
            end_count <= sum;
        end
    end

endmodule

//--- source/node_queue.sv
// Path queue: circular buffer of (index, count) slots with de-duplicating search
`timescale 1ns/10ps

`include "path_settings.svh"

module node_queue
    import path_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        push,
    input  logic        pop,
    input  logic        update,
    input  logic        clear,
    input  logic        seed_idx_sel,

    input  node_idx_t   start_node,
    input  node_idx_t   next_node_idx,
    input  path_count_t sum,

    output logic        empty,
    output logic        match,
    output node_idx_t   head_idx,
    output path_count_t match_count,
    output path_count_t popped_count
);

    // Slot storage
    node_idx_t   idx_mem   [`QUEUE_DEPTH];
    path_count_t count_mem [`QUEUE_DEPTH];
    logic [`QUEUE_DEPTH-1:0] valid;

    queue_ptr_t wr_ptr;
    queue_ptr_t rd_ptr;
    queue_ptr_t wr_slot;
    queue_ptr_t prev_rd_ptr;
    queue_ptr_t match_ptr;

    node_idx_t  wr_idx;

    // A clear restarts the queue at slot 0, the seed lands there in the same cycle
    assign wr_slot = clear ? '0 : wr_ptr;
    assign wr_idx  = seed_idx_sel ? start_node : next_node_idx;

    // Slot popped last, its count is still intact
    assign prev_rd_ptr  = rd_ptr - 1'b1;
    assign popped_count = count_mem[prev_rd_ptr];

    assign head_idx = idx_mem[rd_ptr];
    assign empty    = (wr_ptr == rd_ptr) && !valid[rd_ptr];

    // Associative search over the valid slots
    always_comb begin
        match     = 1'b0;
        match_ptr = '0;
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            if (valid[i] && (idx_mem[i] == next_node_idx)) begin
                match     = 1'b1;
                match_ptr = queue_ptr_t'(i);
            end
        end
    end

    assign match_count = count_mem[match_ptr];

    // Pointers and valid flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            valid  <= '0;
        end else begin
            if (clear) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                valid  <= '0;
            end

            if (push) begin
                valid[wr_slot] <= 1'b1;
                wr_ptr         <= wr_slot + 1'b1;
            end else if (pop) begin
                // Freed slot drops out of the search
                valid[rd_ptr] <= 1'b0;
                rd_ptr        <= rd_ptr + 1'b1;
            end
        end
    end

    // Slot contents
    always_ff @(posedge clk) begin
        if (push) begin
            idx_mem[wr_slot]   <= wr_idx;
            count_mem[wr_slot] <= sum;
        end else if (update) begin
            // In-place merge, pointers stay put
            count_mem[match_ptr] <= sum;
        end
    end

endmodule

//--- source/path_count_ctrl.sv
// Walk controller: breadth first FSM with registered fetch outputs and done flag
`timescale 1ns/10ps

module path_count_ctrl
    import path_types_pkg::*;
    import path_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_run,

    input  succ_cnt_t next_node_counter,

    input  logic      empty,
    input  logic      match,
    input  logic      end_hit,
    input  node_idx_t head_idx,

    output logic      push,
    output logic      pop,
    output logic      update,
    output logic      seed_idx_sel,
    output logic      clear,
    output logic      end_load,
    output logic      end_add,
    output add_base_t add_base,

    output node_idx_t node_idx,
    output logic      rd_next_node,
    output logic      done
);

    walk_state_t state;
    walk_state_t state_next;

    // Next values of the registered outputs
    node_idx_t   node_idx_next;
    logic        rd_next_node_next;
    logic        done_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            node_idx     <= '0;
            rd_next_node <= 1'b0;
            done         <= 1'b0;
        end else begin
            state        <= state_next;
            node_idx     <= node_idx_next;
            rd_next_node <= rd_next_node_next;
            done         <= done_next;
        end
    end

    always_comb begin
        state_next        = state;

        push              = 1'b0;
        pop               = 1'b0;
        update            = 1'b0;
        seed_idx_sel      = 1'b0;
        clear             = 1'b0;
        end_load          = 1'b0;
        end_add           = 1'b0;
        add_base          = BASE_NEW;

        node_idx_next     = node_idx;
        // Fetch request is a single cycle pulse
        rd_next_node_next = 1'b0;
        done_next         = done;

        case (state)
            IDLE: begin
                if (start_run) begin
                    // Empty the queue and seed it with (start_node, 1)
                    clear        = 1'b1;
                    push         = 1'b1;
                    seed_idx_sel = 1'b1;
                    add_base     = BASE_SEED;

                    // End index loaded, end count starts at 0
                    end_load     = 1'b1;

                    state_next   = POP;
                end
            end

            POP: begin
                if (empty) begin
                    // Walk complete, end count holds the answer
                    done_next  = 1'b1;
                    state_next = FINISHED;
                end else begin
                    // Head leaves the queue, its count stays readable in the freed slot
                    pop               = 1'b1;
                    node_idx_next     = head_idx;
                    rd_next_node_next = 1'b1;
                    state_next        = WAIT_LIST;
                end
            end

            WAIT_LIST: begin
                // Memory latches node_idx at the end of this cycle
                state_next = PUSH;
            end

            PUSH: begin
                // One successor per cycle, end node takes priority over a queue match
                if (end_hit) begin
                    end_add  = 1'b1;
                    add_base = BASE_END;
                end else if (match) begin
                    update   = 1'b1;
                    add_base = BASE_MATCH;
                end else begin
                    push     = 1'b1;
                    add_base = BASE_NEW;
                end

                // Last successor of this node
                if (next_node_counter == succ_cnt_t'(1)) begin
                    state_next = POP;
                end
            end

            FINISHED: begin
                // Hold done until the run request goes away
                if (!start_run) begin
                    done_next  = 1'b0;
                    state_next = IDLE;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

//--- source/path_count_top.sv
// Path counter top: controller, node queue and count accumulator
`timescale 1ns/10ps

module path_count_top
    import path_types_pkg::*;
    import path_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_run,
    input  node_idx_t   start_node,
    input  node_idx_t   end_node,
    input  node_idx_t   next_node_idx,
    input  succ_cnt_t   next_node_counter,
    output node_idx_t   node_idx,
    output logic        rd_next_node,
    output logic        done,
    output path_count_t path_count
);

    // Controller strobes
    logic        push;
    logic        pop;
    logic        update;
    logic        seed_idx_sel;
    logic        clear;
    logic        end_load;
    logic        end_add;
    add_base_t   add_base;

    // Queue status and data
    logic        empty;
    logic        match;
    node_idx_t   head_idx;
    path_count_t match_count;
    path_count_t popped_count;

    // Accumulator results
    path_count_t sum;
    logic        end_hit;

    path_count_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_run         (start_run),
        .next_node_counter (next_node_counter),
        .empty             (empty),
        .match             (match),
        .end_hit           (end_hit),
        .head_idx          (head_idx),
        .push              (push),
        .pop               (pop),
        .update            (update),
        .seed_idx_sel      (seed_idx_sel),
        .clear             (clear),
        .end_load          (end_load),
        .end_add           (end_add),
        .add_base          (add_base),
        .node_idx          (node_idx),
        .rd_next_node      (rd_next_node),
        .done              (done)
    );

    node_queue u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .pop           (pop),
        .update        (update),
        .clear         (clear),
        .seed_idx_sel  (seed_idx_sel),
        .start_node    (start_node),
        .next_node_idx (next_node_idx),
        .sum           (sum),
        .empty         (empty),
        .match         (match),
        .head_idx      (head_idx),
        .match_count   (match_count),
        .popped_count  (popped_count)
    );

    count_accumulator u_accum (
        .clk           (clk),
        .rst_n         (rst_n),
        .end_load      (end_load),
        .end_add       (end_add),
        .end_node      (end_node),
        .next_node_idx (next_node_idx),
        .add_base      (add_base),
        .match_count   (match_count),
        .popped_count  (popped_count),
        .sum           (sum),
        .end_hit       (end_hit),
        .path_count    (path_count)
    );

endmodule

//--- source/path_ctrl_pkg.sv
// Path counter control types: walk FSM states and adder base selection
package path_ctrl_pkg;

    // Walk FSM states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        POP       = 3'd1,
        WAIT_LIST = 3'd2,
        PUSH      = 3'd3,
        FINISHED  = 3'd4
    } walk_state_t;

    // Base term that the popped count is added to
    // BASE_SEED has no popped term, the sum is the constant 1
    typedef enum logic [1:0] {
        BASE_SEED  = 2'd0,
        BASE_END   = 2'd1,
        BASE_MATCH = 2'd2,
        BASE_NEW   = 2'd3
    } add_base_t;

endpackage

//--- source/path_settings.svh
// Path counter settings: index, count and successor-counter widths and queue depth
`ifndef PATH_SETTINGS_SVH
`define PATH_SETTINGS_SVH

// Node index and path count widths
`define NODE_IDX_WIDTH 10
`define COUNT_WIDTH    24

// Remaining-successor counter from the graph memory
`define SUCC_CNT_WIDTH 5

// Queue slots, must be a power of two
`define QUEUE_DEPTH    32

`endif

//--- source/path_types_pkg.sv
// Path counter data types for node indices, path counts and queue pointers
`include "path_settings.svh"

package path_types_pkg;

    // Node index as used by the graph memory
    typedef logic [`NODE_IDX_WIDTH-1:0] node_idx_t;

    // Number of paths found to a node
    typedef logic [`COUNT_WIDTH-1:0] path_count_t;

    // Slot pointer, wraps naturally at QUEUE_DEPTH
    typedef logic [$clog2(`QUEUE_DEPTH)-1:0] queue_ptr_t;

    typedef logic [`SUCC_CNT_WIDTH-1:0] succ_cnt_t;

endpackage

//--- testbench/path_count_tb.sv
// Path counter testbench: graph memory model, reference walk and self-checking runs
`timescale 1ns/10ps

module path_count_tb
    import path_types_pkg::*;
();

    localparam int MAX_NODES    = 24;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 20;
    localparam int HOLD_CYCLES  = 4;
    localparam int RANDOM_RUNS  = 20;

    logic        clk;
    logic        rst_n;
    logic        start_run;
    node_idx_t   start_node;
    node_idx_t   end_node;
    node_idx_t   next_node_idx     = '1;
    succ_cnt_t   next_node_counter = '0;
    node_idx_t   node_idx;
    logic        rd_next_node;
    logic        done;
    path_count_t path_count;

    // Adjacency list, successors of node k sit in succ_tab[k]
    int num_succ [MAX_NODES];
    int succ_tab [MAX_NODES][MAX_NODES];

    // Expected results of the current run
    path_count_t exp_count;
    int          exp_pops;
    int          rd_pulses;
    logic        done_q;

    // Nodes in the order the reference walk pops them
    int          exp_order [$];

    int stim_errors;
    int stim_checks;
    int cmp_errors;
    int cmp_checks;
    int tests_run;
    int tests_failed;
    int cycle_count;
    int cycle_limit = 2 * (RESET_CYCLES + IDLE_CYCLES + 10);
    logic [31:0] rng_state = 32'h4c06f2de;

    // Graph memory state
    int   mem_node;
    int   mem_pos;
    int   pending_node;
    logic presenting = 1'b0;
    logic pending    = 1'b0;

    tb_clock_gen u_clk_gen (
        .clk (clk)
    );

    path_count_top UUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_run         (start_run),
        .start_node        (start_node),
        .end_node          (end_node),
        .next_node_idx     (next_node_idx),
        .next_node_counter (next_node_counter),
        .node_idx          (node_idx),
        .rd_next_node      (rd_next_node),
        .done              (done),
        .path_count        (path_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function int rand_below(input int limit);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % limit);
    endfunction

    function int error_total();
        return stim_errors + cmp_errors;
    endfunction

    task automatic clear_graph();
        for (int k = 0; k < MAX_NODES; k++) begin
            num_succ[k] = 0;
        end
    endtask

    task automatic add_edge(input int from_n, input int to_n);
        succ_tab[from_n][num_succ[from_n]] = to_n;
        num_succ[from_n] = num_succ[from_n] + 1;
    endtask

    function automatic bit has_edge(input int from_n, input int to_n);
        for (int i = 0; i < num_succ[from_n]; i++) begin
            if (succ_tab[from_n][i] == to_n) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Random DAG, edges only point to higher indices and the last node is the end
    task automatic build_random_graph(output int node_cnt, output int start_n);
        int want;
        int span;
        int cand;
        node_cnt = 6 + rand_below(MAX_NODES - 5);
        clear_graph();
        for (int k = 0; k < node_cnt - 1; k++) begin
            span = node_cnt - 1 - k;
            want = 1 + rand_below(3);
            if (want > span) begin
                want = span;
            end
            while (num_succ[k] < want) begin
                cand = k + 1 + rand_below(span);
                if (!has_edge(k, cand)) begin
                    add_edge(k, cand);
                end
            end
        end
        start_n = rand_below(node_cnt - 1);
    endtask

    // Reference walk: FIFO of (node, count), merge in place, end node collects counts
    // The pop order lands in exp_order
    function automatic path_count_t ref_path_count(input int start_n, input int end_n,
                                                   output int pops, output int edges);
        int          q_node [$];
        path_count_t q_cnt  [$];
        int          node;
        int          succ;
        int          hit;
        path_count_t cnt;
        path_count_t end_cnt;
        end_cnt = '0;
        pops    = 0;
        edges   = 0;
        exp_order.delete();
        q_node.push_back(start_n);
        q_cnt.push_back(path_count_t'(1));
        while (q_node.size() > 0) begin
            node = q_node.pop_front();
            cnt  = q_cnt.pop_front();
            pops = pops + 1;
            exp_order.push_back(node);
            for (int i = 0; i < num_succ[node]; i++) begin
                succ  = succ_tab[node][i];
                edges = edges + 1;
                hit   = -1;
                for (int j = 0; j < q_node.size(); j++) begin
                    if (q_node[j] == succ) begin
                        hit = j;
                    end
                end
                if (succ == end_n) begin
                    end_cnt = end_cnt + cnt;
                end else if (hit >= 0) begin
                    q_cnt[hit] = q_cnt[hit] + cnt;
                end else begin
                    q_node.push_back(succ);
                    q_cnt.push_back(cnt);
                end
            end
        end
        return end_cnt;
    endfunction

    // Graph memory: latch node_idx on a fetch, then one successor per rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            presenting = 1'b0;
            pending    = 1'b0;
        end else begin
            // Entry shown last was consumed at the rising edge just passed
            if (presenting) begin
                mem_pos = mem_pos + 1;
                if (mem_pos == num_succ[mem_node]) begin
                    presenting = 1'b0;
                end
            end
            if (pending) begin
                mem_node   = pending_node;
                mem_pos    = 0;
                presenting = 1'b1;
                pending    = 1'b0;
            end
            if (rd_next_node) begin
                pending_node = int'(node_idx);
                pending      = 1'b1;
            end
        end
        if (presenting) begin
            next_node_idx     = node_idx_t'(succ_tab[mem_node][mem_pos]);
            next_node_counter = succ_cnt_t'(num_succ[mem_node] - mem_pos);
        end else begin
            next_node_idx     = '1;
            next_node_counter = '0;
        end
    end

    // Compare on the rising edge of done, fetch pulses counted per run
    always @(negedge clk) begin
        if (!rst_n) begin
            done_q     = 1'b0;
            rd_pulses  = 0;
            cmp_errors = 0;
            cmp_checks = 0;
        end else begin
            if (rd_next_node) begin
                // Fetched node follows the reference pop order
                if (rd_pulses < exp_order.size()) begin
                    cmp_checks = cmp_checks + 1;
                    assert (int'(node_idx) == exp_order[rd_pulses]) else begin
                        $display("Mismatch at %0t: node_idx = %0d, expected %0d",
                                 $time, node_idx, exp_order[rd_pulses]);
                        cmp_errors = cmp_errors + 1;
                    end
                end
                rd_pulses = rd_pulses + 1;
            end
            if (done && !done_q) begin
                cmp_checks = cmp_checks + 2;
                assert (path_count == exp_count) else begin
                    $display("Mismatch at %0t: path_count = %0d, expected %0d",
                             $time, path_count, exp_count);
                    cmp_errors = cmp_errors + 1;
                end
                assert (rd_pulses == exp_pops) else begin
                    $display("Mismatch at %0t: rd_next_node pulses = %0d, expected %0d",
                             $time, rd_pulses, exp_pops);
                    cmp_errors = cmp_errors + 1;
                end
                rd_pulses = 0;
            end
            done_q = done;
        end
    end

    task automatic run_walk(input int start_n, input int end_n);
        int edges;
        exp_count   = ref_path_count(start_n, end_n, exp_pops, edges);
        cycle_limit = cycle_limit + 2 * (10 + HOLD_CYCLES + 3 * exp_pops + edges);
        start_node  = node_idx_t'(start_n);
        end_node    = node_idx_t'(end_n);
        start_run   = 1'b1;
        // Walk length depends on the graph
        do begin
            @(negedge clk);
        end while (!done);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            stim_checks = stim_checks + 1;
            assert (done == 1'b1) else begin
                $display("Mismatch at %0t: done = %0b, expected 1", $time, done);
                stim_errors = stim_errors + 1;
            end
        end
        start_run = 1'b0;
        @(negedge clk);
        stim_checks = stim_checks + 1;
        assert (done == 1'b0) else begin
            $display("Mismatch at %0t: done = %0b, expected 0", $time, done);
            stim_errors = stim_errors + 1;
        end
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run = tests_run + 1;
        if (error_total() == errs_before) begin
            $display("PASS  %s", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("FAIL  %s", name);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: no result after %0d cycles", cycle_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int          start_n;
        int          node_cnt;
        int          errs_before;
        start_run    = 1'b0;
        start_node   = '0;
        end_node     = '0;
        rst_n        = 1'b0;
        stim_errors  = 0;
        stim_checks  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Idle, nothing may move while start_run is low
        errs_before = error_total();
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            stim_checks = stim_checks + 2;
            assert (done == 1'b0) else begin
                $display("Mismatch at %0t: done = %0b, expected 0", $time, done);
                stim_errors = stim_errors + 1;
            end
            assert (rd_next_node == 1'b0) else begin
                $display("Mismatch at %0t: rd_next_node = %0b, expected 0", $time, rd_next_node);
                stim_errors = stim_errors + 1;
            end
        end
        report_test("idle after reset", errs_before);

        errs_before = error_total();
        clear_graph();
        add_edge(3, 7);
        run_walk(3, 7);
        report_test("single edge 3 to 7", errs_before);

        // Diamond into a ladder, paths merge in the queue at node 3
        errs_before = error_total();
        clear_graph();
        add_edge(0, 1);
        add_edge(0, 2);
        add_edge(1, 3);
        add_edge(2, 3);
        add_edge(3, 4);
        add_edge(3, 5);
        add_edge(4, 6);
        add_edge(5, 6);
        run_walk(0, 6);
        // Two ways into node 3 times two ways on to node 6
        stim_checks = stim_checks + 1;
        assert (path_count == path_count_t'(4)) else begin
            $display("Mismatch at %0t: path_count = %0d, expected 4", $time, path_count);
            stim_errors = stim_errors + 1;
        end
        report_test("diamond and ladder", errs_before);

        // Second run with a new start and end, the end count must restart
        errs_before = error_total();
        clear_graph();
        add_edge(2, 3);
        add_edge(2, 4);
        add_edge(3, 4);
        add_edge(3, 5);
        add_edge(4, 5);
        run_walk(2, 5);
        report_test("second run, start 2 end 5", errs_before);

        for (int r = 0; r < RANDOM_RUNS; r++) begin
            errs_before = error_total();
            build_random_graph(node_cnt, start_n);
            run_walk(start_n, node_cnt - 1);
            report_test($sformatf("random graph %0d, %0d nodes, start %0d, %0d paths",
                                  r, node_cnt, start_n, exp_count), errs_before);
        end

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, stim_checks + cmp_checks, error_total());
        if (error_total() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
// Testbench clock generator: free running clock with a 20 ns period
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule
